// File: all.f
+incdir+verif
src/intr_pkg.sv
src/intr_pending.sv
src/nesting_ismu.sv
src/level_stack.sv
src/intr_ctrl_top.sv
verif/tb_intr_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_intr_ctrl -o sim_intr_ctrl

out="$(./obj_dir/sim_intr_ctrl 2>&1)" || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: verif/tb_intr_tasks.svh
// Check, wait and drive tasks, directed tests and xorshift for the interrupt controller testbench
`ifndef TB_INTR_TASKS_SVH
`define TB_INTR_TASKS_SVH

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
endtask

task automatic check_eq(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, actual, expected));
    end
endtask

// Returns just after the falling edge where req_valid is seen high
task automatic wait_valid();
    int n;
    n = 0;
    while (req_valid !== 1'b1) begin
        if (n == VALID_TIMEOUT) begin
            abort_run($sformatf("No interrupt offer appeared within %0d cycles", n));
        end else begin
            @(negedge clk);
            n++;
        end
    end
endtask

task automatic expect_no_offer(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        check_eq("req_valid", req_valid, 0);
    end
endtask

task automatic accept();
    req_ready = 1'b1;
    @(negedge clk);
    req_ready = 1'b0;
endtask

task automatic do_eoi();
    eoi = 1'b1;
    @(negedge clk);
    eoi = 1'b0;
    m_stack.delete(m_stack.size() - 1);
    check_eq("cur_level", cur_level, top_level());
endtask

// One-cycle pulse so every source sees a fresh rising edge
task automatic raise_edges(input logic [NUM_SRC-1:0] mask);
    intr_src = mask;
    @(negedge clk);
    intr_src = '0;
    m_pend   = m_pend | mask;
endtask

task automatic set_prio(input int src, input int p);
    intr_prio[src*LVL_W +: LVL_W] = LVL_W'(p);
endtask

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// Early ready is already high while the offer is still on its way
task automatic serve_offer(input int hold, input bit early, input int exp_id, input int exp_lvl);
    req_ready = early;
    wait_valid();
    check_eq("req_id", req_id, exp_id);
    check_eq("req_level", req_level, exp_lvl);
    if (early) begin
        @(negedge clk);
        req_ready = 1'b0;
    end else begin
        repeat (hold) begin
            @(negedge clk);
            check_eq("req_valid", req_valid, 1);
            check_eq("req_id", req_id, exp_id);
            check_eq("req_level", req_level, exp_lvl);
        end
        accept();
    end
    m_pend[exp_id] = 1'b0;
    m_stack.push_back(exp_lvl);
    check_eq("cur_level", cur_level, exp_lvl);
    check_eq("req_valid", req_valid, 0);
endtask

task automatic test_single();
    set_prio(2, 3);
    raise_edges(8'h04);
    serve_offer(0, 1'b0, 2, 3);
    do_eoi();
    expect_no_offer(10);
endtask

// Sources 5 and 6 tie at level 6, the higher id goes first
task automatic test_select_tie();
    set_prio(1, 4);
    set_prio(5, 6);
    set_prio(6, 6);
    raise_edges(8'h62);
    serve_offer(5, 1'b0, 6, 6);
    do_eoi();
    serve_offer(0, 1'b0, 5, 6);
    do_eoi();
    serve_offer(0, 1'b0, 1, 4);
    do_eoi();
endtask

task automatic test_nesting();
    set_prio(0, 2);
    set_prio(4, 6);
    set_prio(3, 1);
    raise_edges(8'h01);
    serve_offer(0, 1'b0, 0, 2);
    raise_edges(8'h10);
    serve_offer(0, 1'b0, 4, 6);
    raise_edges(8'h08);
    expect_no_offer(10);
    do_eoi();
    expect_no_offer(10);
    do_eoi();
    serve_offer(0, 1'b0, 3, 1);
    do_eoi();
endtask

// Source 7 disabled, source 6 at priority 0
task automatic test_masking();
    intr_enable[7] = 1'b0;
    set_prio(7, 5);
    set_prio(6, 0);
    raise_edges(8'h80);
    expect_no_offer(10);
    raise_edges(8'h40);
    expect_no_offer(10);
    intr_enable[7] = 1'b1;
    serve_offer(0, 1'b0, 7, 5);
    do_eoi();
    expect_no_offer(10);
endtask

`endif

// File: verif/tb_intr_ctrl.sv
// Testbench top for the interrupt controller with clock, reset, DUT, model and test sequence
`timescale 1ns/100ps
`default_nettype none

module tb_intr_ctrl import intr_pkg::*; ();

    localparam int VALID_TIMEOUT = 24;
    localparam int ROUNDS        = 16;

    logic               clk = 1'b0;
    logic               rst;
    logic [NUM_SRC-1:0] intr_src;
    logic [NUM_SRC-1:0] intr_enable;
    logic [PRIO_W-1:0]  intr_prio;
    logic               req_valid;
    logic [ID_W-1:0]    req_id;
    logic [LVL_W-1:0]   req_level;
    logic               req_ready;
    logic               eoi;
    logic [LVL_W-1:0]   cur_level;

    // Model of the pending bits and the nesting stack
    logic [NUM_SRC-1:0] m_pend;
    int                 m_stack[$];
    logic [31:0]        rng;

    intr_ctrl_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .intr_src    (intr_src),
        .intr_enable (intr_enable),
        .intr_prio   (intr_prio),
        .req_valid   (req_valid),
        .req_id      (req_id),
        .req_level   (req_level),
        .req_ready   (req_ready),
        .eoi         (eoi),
        .cur_level   (cur_level)
    );

    always #4 clk = ~clk;

    // Level 0 when no handler is active
    function automatic int top_level();
        return (m_stack.size() == 0) ? 0 : m_stack[$];
    endfunction

    // Highest priority above the current level, ties to the higher id, -1 if none
    function automatic int model_winner(output int lvl);
        int best;
        int p;
        best = -1;
        lvl  = top_level();
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            p = int'(intr_prio[i*LVL_W +: LVL_W]);
            if (m_pend[i] && intr_enable[i] && p > lvl) begin
                best = i;
                lvl  = p;
            end
        end
        return best;
    endfunction

    `include "tb_intr_tasks.svh"

    // Serve offers until the model has no eligible source left
    task automatic service_until_idle();
        int id;
        int lvl;
        id = model_winner(lvl);
        while (id >= 0) begin
            rng = xorshift(rng);
            // Sometimes end a handler before the next take
            if (m_stack.size() != 0 && rng[1:0] == 2'b00) begin
                do_eoi();
            end else begin
                serve_offer(int'(rng[4:2]), rng[5], id, lvl);
            end
            id = model_winner(lvl);
        end
    endtask

    task automatic test_random();
        logic [NUM_SRC-1:0] mask;
        // Fixed enables with source 5 masked off
        intr_enable = 8'hDF;
        for (int i = 0; i < NUM_SRC; i++) begin
            rng = xorshift(rng);
            set_prio(i, int'(rng[LVL_W-1:0]));
        end
        repeat (4) @(negedge clk);
        service_until_idle();
        for (int r = 0; r < ROUNDS; r++) begin
            rng  = xorshift(rng);
            mask = rng[15:8];
            raise_edges(mask);
            repeat (4) @(negedge clk);
            service_until_idle();
        end
        while (m_stack.size() != 0) begin
            do_eoi();
            service_until_idle();
        end
        expect_no_offer(10);
    endtask

    initial begin
        rst         = 1'b1;
        intr_src    = '0;
        intr_enable = '1;
        intr_prio   = '0;
        req_ready   = 1'b0;
        eoi         = 1'b0;
        m_pend      = '0;
        rng         = 32'h6f6e_6686;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        check_eq("cur_level", cur_level, 0);
        check_eq("req_valid", req_valid, 0);
        test_single();
        test_select_tie();
        test_nesting();
        test_masking();
        test_random();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/intr_ctrl_top.sv
// Top level of the nested interrupt controller, pending register, resolver and stack
`timescale 1ns/100ps
`default_nettype none

module intr_ctrl_top import intr_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [NUM_SRC-1:0] intr_src,
    input  wire logic [NUM_SRC-1:0] intr_enable,
    input  wire logic [PRIO_W-1:0]  intr_prio,
    output logic                    req_valid,
    output logic      [ID_W-1:0]    req_id,
    output logic      [LVL_W-1:0]   req_level,
    input  wire logic               req_ready,
    input  wire logic               eoi,
    output logic      [LVL_W-1:0]   cur_level
);

    logic [NUM_SRC-1:0] pending;
    logic               take;
    logic [ID_W-1:0]    take_id;
    logic [LVL_W-1:0]   take_level;

    intr_pending pending_i (
        .clk      (clk),
        .rst      (rst),
        .intr_src (intr_src),
        .take     (take),
        .take_id  (take_id),
        .pending  (pending)
    );

    // Resolver owns the handshake and issues the take pulse
    nesting_ismu ismu_i (
        .clk         (clk),
        .rst         (rst),
        .pending     (pending),
        .intr_enable (intr_enable),
        .intr_prio   (intr_prio),
        .cur_level   (cur_level),
        .req_valid   (req_valid),
        .req_id      (req_id),
        .req_level   (req_level),
        .req_ready   (req_ready),
        .take        (take),
        .take_id     (take_id),
        .take_level  (take_level)
    );

    level_stack stack_i (
        .clk        (clk),
        .rst        (rst),
        .take       (take),
        .take_level (take_level),
        .eoi        (eoi),
        .cur_level  (cur_level)
    );

endmodule

`default_nettype wire

// File: src/level_stack.sv
// Nesting stack of accepted levels with the current level output
`timescale 1ns/100ps
`default_nettype none

module level_stack import intr_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             take,
    input  wire logic [LVL_W-1:0] take_level,
    input  wire logic             eoi,
    output logic      [LVL_W-1:0] cur_level
);

    logic [LVL_W-1:0] stack_mem [NEST_DEPTH];
    logic [$clog2(NEST_DEPTH+1)-1:0] count;
    logic [$clog2(NEST_DEPTH+1)-1:0] top_idx;

    assign top_idx = count - 1'b1;

    // Level 0 when no handler is active
    assign cur_level = (count == '0) ? '0 : stack_mem[top_idx];

    // Entry written by each take
    always_ff @(posedge clk) begin
        if (take && eoi) begin
            // pop then push lands on the same slot
            stack_mem[top_idx] <= take_level;
        end else if (take) begin
            stack_mem[count] <= take_level;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (take && !eoi) begin
            count <= count + 1'b1;
        end else if (eoi && !take) begin
            count <= count - 1'b1;
        end
    end

    no_pop_empty_a: assert property (
        @(posedge clk) disable iff (rst)
        eoi |-> count != '0
    ) else $error("eoi with no active handler");

    no_push_full_a: assert property (
        @(posedge clk) disable iff (rst)
        take && !eoi |-> count < NEST_DEPTH
    ) else $error("nesting stack overflow");

    // Levels must strictly rise while nesting
    push_rises_a: assert property (
        @(posedge clk) disable iff (rst)
        take |-> take_level > cur_level
    ) else $error("pushed level %0d not above top %0d", take_level, cur_level);

endmodule

`default_nettype wire

// File: src/nesting_ismu.sv
// Three-stage nesting priority resolver with valid/ready offer and take pulse
`timescale 1ns/100ps
`default_nettype none

module nesting_ismu import intr_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [NUM_SRC-1:0] pending,
    input  wire logic [NUM_SRC-1:0] intr_enable,
    input  wire logic [PRIO_W-1:0]  intr_prio,
    input  wire logic [LVL_W-1:0]   cur_level,
    output logic                    req_valid,
    output logic      [ID_W-1:0]    req_id,
    output logic      [LVL_W-1:0]   req_level,
    input  wire logic               req_ready,
    output logic                    take,
    output logic      [ID_W-1:0]    take_id,
    output logic      [LVL_W-1:0]   take_level
);

    // Stage 1 registers
    logic               s1_vld;
    logic [NUM_SRC-1:0] s1_elig;
    logic [PRIO_W-1:0]  s1_prio;
    logic [LVL_W-1:0]   s1_lvl;

    // Scan result
    logic               win_found;
    logic [ID_W-1:0]    win_id;
    logic [LVL_W-1:0]   win_lvl;

    // Stage 2 registers
    logic               s2_found;
    logic [ID_W-1:0]    s2_id;
    logic [LVL_W-1:0]   s2_lvl;

    // Handshake completes on this edge
    assign take       = req_valid & req_ready;
    assign take_id    = req_id;
    assign take_level = req_level;

    // Stage 1, mask pending with enables and sample the level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= ~take;
        end
    end

    always_ff @(posedge clk) begin
        s1_elig <= pending & intr_enable;
        s1_prio <= intr_prio;
        s1_lvl  <= cur_level;
    end

    // Scan from the top source down, strict compare keeps the higher id on ties
    // Starting from the sampled level means priority 0 never wins
    always_comb begin
        win_found = 1'b0;
        win_id    = '0;
        win_lvl   = s1_lvl;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (s1_elig[i] && (s1_prio[i*LVL_W +: LVL_W] > win_lvl)) begin
                win_found = 1'b1;
                win_id    = ID_W'(i);
                win_lvl   = s1_prio[i*LVL_W +: LVL_W];
            end
        end
    end

    // Stage 2, winner register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_found <= 1'b0;
        end else begin
            s2_found <= win_found & s1_vld & ~take;
        end
    end

    always_ff @(posedge clk) begin
        s2_id  <= win_id;
        s2_lvl <= win_lvl;
    end

    // Stage 3, offer register; a held offer is never replaced
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid <= 1'b0;
            req_id    <= '0;
            req_level <= '0;
        end else if (take) begin
            req_valid <= 1'b0;
        end else if (!req_valid) begin
            req_valid <= s2_found;
            req_id    <= s2_id;
            req_level <= s2_lvl;
        end
    end

    offer_stable_a: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_id) && $stable(req_level)
    ) else $error("offer changed under back-pressure");

    // Takes flush the pipeline, so an offer is never at or below the live level
    offer_above_level_a: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> req_level > cur_level
    ) else $error("offer level %0d not above current level %0d", req_level, cur_level);

endmodule

`default_nettype wire

// File: src/intr_pending.sv
// Rising edge detection and per-source pending bits for the interrupt controller
`timescale 1ns/100ps
`default_nettype none

module intr_pending import intr_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [NUM_SRC-1:0] intr_src,
    input  wire logic               take,
    input  wire logic [ID_W-1:0]    take_id,
    output logic      [NUM_SRC-1:0] pending
);

    logic [NUM_SRC-1:0] src_q;
    logic [NUM_SRC-1:0] rise;
    logic [NUM_SRC-1:0] clr_mask;

    // Edge against the sample from the previous cycle
    assign rise = intr_src & ~src_q;

    // One-hot clear for the source being taken
    always_comb begin
        clr_mask          = '0;
        clr_mask[take_id] = take;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_q   <= '0;
            pending <= '0;
        end else begin
            src_q   <= intr_src;
            // set wins over clear on the same bit
            pending <= (pending & ~clr_mask) | rise;
        end
    end

    // The resolver only offers pending sources, so a take must hit a set bit
    take_of_pending_a: assert property (
        @(posedge clk) disable iff (rst)
        take |-> pending[take_id]
    ) else $error("take for source %0d which is not pending", take_id);

endmodule

`default_nettype wire

// File: src/intr_pkg.sv
// Package with the interrupt controller's shared localparams
`default_nettype none

package intr_pkg;

    // Number of edge-triggered interrupt sources
    localparam int NUM_SRC = 8;

    // Width of a source id
    localparam int ID_W = 3;

    // Width of a priority or a nesting level
    localparam int LVL_W = 3;

    // Nesting stack depth
    // Levels strictly rise on each push, so levels 1..7 always fit
    localparam int NEST_DEPTH = 7;

    // Flat priority vector, source i sits at bits 3i+2 down to 3i
    localparam int PRIO_W = NUM_SRC * LVL_W;

endpackage

`default_nettype wire
